//--- all.f
+incdir+common
common/cache_pkg.sv
cache/cacheStore.sv
cache/cacheCtrl.sv
verilog/cacheTop.sv
sim/tbClock.sv
sim/cache_props.sv
sim/cacheTb.sv

//--- cache/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheCtrl (
	input wire clk,
	input wire reset,
	input wire cachePkg::cacheOpT op,
	input wire cachePkg::indexT index,
	input wire cachePkg::tagT tag,
	input wire isHit,
	input wire cachePkg::wayT hitWay,
	input wire cachePkg::wayT victimWay,
	input wire victimDirty,
	input wire cachePkg::tagT victimTag,
	input wire memRdReady,
	input wire memWrDone,
	output logic fillEn,
	output logic writeEn,
	output logic touchEn,
	output logic cleanEn,
	output logic invalEn,
	output cachePkg::wayT way,
	output logic memRdReq,
	output cachePkg::addrT memRdAddr,
	output logic memWrReq,
	output cachePkg::addrT memWrAddr,
	output logic done,
	output logic hit
);

	cachePkg::ctrlStateT state;
	cachePkg::wayT wayReg; // way under flush or refill
	logic missed; // current op went to memory

	// ------------------------------
	// sequencing
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cachePkg::sIdle;
			missed <= 1'b0;
		end else begin
			case (state)
				cachePkg::sIdle: begin
					if (op == cachePkg::opInvalidate) begin
						if (isHit && victimDirty) begin
							state <= cachePkg::sFlush;
							missed <= 1'b1;
						end else begin
							state <= cachePkg::sDone; // clean or absent
						end
					end else if (op != cachePkg::opNone) begin
						if (isHit) begin
							state <= cachePkg::sDone;
						end else begin
							missed <= 1'b1;
							if (victimDirty)
								state <= cachePkg::sFlush;
							else
								state <= cachePkg::sFill;
						end
					end
				end
				cachePkg::sFlush:
					state <= cachePkg::sFlushWait;
				cachePkg::sFlushWait: begin
					if (memWrDone) begin
						if (op == cachePkg::opInvalidate)
							state <= cachePkg::sDone;
						else
							state <= cachePkg::sFill;
					end
				end
				cachePkg::sFill:
					state <= cachePkg::sFillWait;
				cachePkg::sFillWait:
					if (memRdReady) state <= cachePkg::sIdle; // re-lookup now hits
				cachePkg::sDone: begin
					state <= cachePkg::sIdle;
					missed <= 1'b0;
				end
				default:
					state <= cachePkg::sIdle;
			endcase
		end
	end

	// victim held steady until the fill lands
	always_ff @(posedge clk) begin
		if (state == cachePkg::sIdle)
			wayReg <= victimWay;
	end

	// ------------------------------
	// store strobes
	// ------------------------------

	always_comb begin
		fillEn = 1'b0;
		writeEn = 1'b0;
		touchEn = 1'b0;
		cleanEn = 1'b0;
		invalEn = 1'b0;
		case (state)
			cachePkg::sIdle: begin
				if (isHit) begin
					case (op)
						cachePkg::opRead: touchEn = 1'b1;
						cachePkg::opWrite: writeEn = 1'b1;
						cachePkg::opInvalidate: invalEn = !victimDirty;
						default: ;
					endcase
				end
			end
			cachePkg::sFlushWait: begin
				if (memWrDone) begin
					if (op == cachePkg::opInvalidate)
						invalEn = 1'b1;
					else
						cleanEn = 1'b1;
				end
			end
			cachePkg::sFillWait:
				fillEn = memRdReady;
			default: ;
		endcase
	end

	assign way = (state == cachePkg::sIdle) ? hitWay : wayReg;

	// memory side, line aligned
	assign memRdReq = (state == cachePkg::sFill);
	assign memWrReq = (state == cachePkg::sFlush);
	assign memRdAddr = {tag, index, {`CACHE_OFFSET_W{1'b0}}};
	assign memWrAddr = {victimTag, index, {`CACHE_OFFSET_W{1'b0}}};

	assign done = (state == cachePkg::sDone);
	assign hit = !missed;

endmodule

`default_nettype wire

//--- cache/cacheStore.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheStore (
	input wire clk,
	input wire reset,
	input wire cachePkg::indexT index,
	input wire cachePkg::tagT tag,
	input wire cachePkg::wordSelT wordSel,
	input wire cachePkg::wordT writeData,
	input wire cachePkg::lineT fillLine,
	input wire fillEn,
	input wire writeEn,
	input wire touchEn,
	input wire cleanEn,
	input wire invalEn,
	input wire cachePkg::wayT way,
	output logic isHit,
	output cachePkg::wayT hitWay,
	output cachePkg::wayT victimWay,
	output logic victimDirty,
	output cachePkg::tagT victimTag,
	output cachePkg::lineT victimLine,
	output cachePkg::wordT readData
);

	cachePkg::tagT tagMem [2][`CACHE_SETS];
	cachePkg::lineT dataMem [2][`CACHE_SETS];
	logic valid [2][`CACHE_SETS];
	logic dirty [2][`CACHE_SETS];
	logic lruWay [`CACHE_SETS]; // way that was used least recently

	logic hit0;
	logic hit1;

	// ------------------------------
	// lookup
	// ------------------------------

	assign hit0 = valid[0][index] && (tagMem[0][index] == tag);
	assign hit1 = valid[1][index] && (tagMem[1][index] == tag);
	assign isHit = hit0 | hit1;
	assign hitWay = hit1;

	// on a hit the victim is the hit way itself, so invalidate flushes that line
	always_comb begin
		if (isHit)
			victimWay = hitWay;
		else if (!valid[0][index])
			victimWay = 1'b0;
		else if (!valid[1][index])
			victimWay = 1'b1;
		else
			victimWay = lruWay[index];
	end

	assign victimDirty = valid[victimWay][index] && dirty[victimWay][index];
	assign victimTag = tagMem[victimWay][index];
	assign victimLine = dataMem[victimWay][index];

	assign readData = dataMem[hitWay][index][wordSel*`CACHE_WORD_W +: `CACHE_WORD_W];

	// ------------------------------
	// state bits
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				valid[0][s] <= 1'b0;
				valid[1][s] <= 1'b0;
				dirty[0][s] <= 1'b0;
				dirty[1][s] <= 1'b0;
				lruWay[s] <= 1'b0;
			end
		end else begin
			if (fillEn) begin
				valid[way][index] <= 1'b1;
				dirty[way][index] <= 1'b0; // fresh from memory
			end
			if (writeEn)
				dirty[way][index] <= 1'b1;
			if (cleanEn)
				dirty[way][index] <= 1'b0;
			if (invalEn)
				valid[way][index] <= 1'b0;

			// the other way becomes least recent
			if (fillEn || writeEn || touchEn)
				lruWay[index] <= ~way;
		end
	end

	// tags and line data
	always_ff @(posedge clk) begin
		if (fillEn) begin
			tagMem[way][index] <= tag;
			dataMem[way][index] <= fillLine;
		end else if (writeEn) begin
			dataMem[way][index][wordSel*`CACHE_WORD_W +: `CACHE_WORD_W] <= writeData;
		end
	end

endmodule

`default_nettype wire

//--- common/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// ------------------------------
// address split
// ------------------------------

`define CACHE_ADDR_W 16 // byte address
`define CACHE_TAG_W 8
`define CACHE_INDEX_W 4
`define CACHE_OFFSET_W 4 // byte within a line

// ------------------------------
// data geometry
// ------------------------------

`define CACHE_WORD_W 32
`define CACHE_WORDS 4 // words per line
`define CACHE_SETS 16

// two ways fixed, one lru bit per set

`endif

//--- common/cache_pkg.sv
`default_nettype none

`include "cache_consts.svh"

package cachePkg;

	typedef logic [`CACHE_ADDR_W-1:0] addrT;
	typedef logic [`CACHE_WORD_W-1:0] wordT;
	typedef logic [`CACHE_WORDS*`CACHE_WORD_W-1:0] lineT; // word 0 in low bits
	typedef logic [`CACHE_TAG_W-1:0] tagT;
	typedef logic [`CACHE_INDEX_W-1:0] indexT;
	typedef logic [$clog2(`CACHE_WORDS)-1:0] wordSelT;
	typedef logic wayT;

	typedef enum logic [1:0] {
		opNone,
		opRead,
		opWrite,
		opInvalidate
	} cacheOpT;

	// controller sequencing
	typedef enum logic [2:0] {
		sIdle,
		sFlush,
		sFlushWait,
		sFill,
		sFillWait,
		sDone
	} ctrlStateT;

endpackage

`default_nettype wire

//--- sim/cacheTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheTb;

	localparam int nTests = 20;
	localparam int maxLat = 6; // longest memory answer, in cycles
	localparam int cycleLimit = 16 + nTests * 2 * (maxLat + 4) + 64;
	localparam int nLines = 1 << (`CACHE_ADDR_W - `CACHE_OFFSET_W);
	localparam int nWords = 1 << (`CACHE_ADDR_W - 2);

	logic clk;
	logic reset;
	cachePkg::cacheOpT op;
	cachePkg::addrT addr;
	cachePkg::wordT writeData;
	logic memRdReady;
	cachePkg::lineT memRdLine;
	logic memWrDone;
	cachePkg::wordT readData;
	logic done;
	logic hit;
	logic memRdReq;
	cachePkg::addrT memRdAddr;
	logic memWrReq;
	cachePkg::addrT memWrAddr;
	cachePkg::lineT memWrLine;

	// stimulus table
	string testName [nTests];
	cachePkg::cacheOpT testOp [nTests];
	cachePkg::addrT testAddr [nTests];
	cachePkg::wordT testData [nTests];
	logic testHit [nTests];
	cachePkg::wordT testExp [nTests];
	int nAdded = 0;

	// memory model and flat view of what every word should hold
	cachePkg::lineT memLines [nLines];
	cachePkg::wordT golden [nWords];
	int rdCount = 0;
	int wrCount = 0;
	cachePkg::addrT lastRdAddr;
	cachePkg::addrT lastWrAddr;
	logic [11:0] rdLine;
	int delay;
	integer seed = 32'hda7975cc;
	int cycles = 0;

	// reference two-way cache, tags and flags only
	cachePkg::tagT refTag [2][`CACHE_SETS];
	logic refValid [2][`CACHE_SETS];
	logic refDirty [2][`CACHE_SETS];
	cachePkg::wayT refLru [`CACHE_SETS];

	tbClock clockGen (.clk(clk));

	cacheTop DUT (
		.clk(clk), .reset(reset), .op(op), .addr(addr), .writeData(writeData),
		.memRdReady(memRdReady), .memRdLine(memRdLine), .memWrDone(memWrDone),
		.readData(readData), .done(done), .hit(hit), .memRdReq(memRdReq),
		.memRdAddr(memRdAddr), .memWrReq(memWrReq), .memWrAddr(memWrAddr),
		.memWrLine(memWrLine)
	);

	function automatic cachePkg::wordT presetWord(input cachePkg::addrT a);
		return {2'b10, a[15:2], 2'b01, ~a[15:2]};
	endfunction

	task automatic stopRun();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkWord(input string name, input cachePkg::wordT expected,
		input cachePkg::wordT actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkHit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error: %s hit expected %b actual %b", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkAddr(input string name, input cachePkg::addrT expected,
		input cachePkg::addrT actual);
		if (actual !== expected) begin
			$display("** Error: %s address expected %h actual %h", name,
				expected, actual);
			stopRun();
		end
	endtask

	task automatic addTest(input string name, input cachePkg::cacheOpT kind,
		input cachePkg::addrT a, input cachePkg::wordT d, input logic h,
		input cachePkg::wordT e);
		testName[nAdded] = name;
		testOp[nAdded] = kind;
		testAddr[nAdded] = a;
		testData[nAdded] = d;
		testHit[nAdded] = h;
		testExp[nAdded] = e;
		nAdded++;
	endtask

	task automatic predictWriteback(input cachePkg::cacheOpT kind, input cachePkg::addrT a,
		output logic wb, output cachePkg::addrT wbAddr);
		cachePkg::indexT idx;
		cachePkg::tagT tg;
		cachePkg::wayT w;
		logic found;
		idx = a[7:4];
		tg = a[15:8];
		wb = 1'b0;
		wbAddr = '0;
		found = 1'b1;
		if (refValid[1][idx] && refTag[1][idx] == tg)
			w = 1'b1;
		else if (refValid[0][idx] && refTag[0][idx] == tg)
			w = 1'b0;
		else
			found = 1'b0;
		if (kind == cachePkg::opInvalidate) begin
			if (found) begin
				wb = refDirty[w][idx];
				wbAddr = {tg, idx, 4'h0};
				refValid[w][idx] = 1'b0;
				refDirty[w][idx] = 1'b0;
			end
		end else begin
			if (!found) begin
				// invalid way first, else least recent
				if (!refValid[0][idx])
					w = 1'b0;
				else if (!refValid[1][idx])
					w = 1'b1;
				else
					w = refLru[idx];
				wb = refValid[w][idx] && refDirty[w][idx];
				wbAddr = {refTag[w][idx], idx, 4'h0};
				refTag[w][idx] = tg;
				refValid[w][idx] = 1'b1;
				refDirty[w][idx] = 1'b0;
			end
			refLru[idx] = ~w;
			if (kind == cachePkg::opWrite)
				refDirty[w][idx] = 1'b1;
		end
	endtask

	// ------------------------------
	// memory model
	// ------------------------------

	always begin
		@(negedge clk);
		if (memRdReq) begin
			rdCount++;
			lastRdAddr = memRdAddr;
			rdLine = memRdAddr[15:4];
			delay = 1 + ($unsigned($random(seed)) % maxLat);
			repeat (delay) @(posedge clk);
			#2;
			memRdLine = memLines[rdLine];
			memRdReady = 1'b1;
			@(posedge clk);
			#2;
			memRdReady = 1'b0;
		end else if (memWrReq) begin
			wrCount++;
			lastWrAddr = memWrAddr;
			memLines[memWrAddr[15:4]] = memWrLine;
			delay = 1 + ($unsigned($random(seed)) % maxLat);
			repeat (delay) @(posedge clk);
			#2;
			memWrDone = 1'b1;
			@(posedge clk);
			#2;
			memWrDone = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (DUT.ctrl.props.failCount != 0) begin
			$display("a controller assertion failed after %0d cycles", cycles);
			stopRun();
		end else if (cycles > cycleLimit) begin
			$display("timeout after %0d cycles, an operation never finished", cycles);
			stopRun();
		end
	end

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		int i;
		int w;
		int rdBefore;
		int wrBefore;
		logic expWb;
		cachePkg::addrT expWbAddr;
		reset = 1'b1;
		op = cachePkg::opNone;
		addr = '0;
		writeData = '0;
		memRdReady = 1'b0;
		memRdLine = '0;
		memWrDone = 1'b0;
		for (i = 0; i < nLines; i++)
			for (w = 0; w < `CACHE_WORDS; w++)
				memLines[i][w*`CACHE_WORD_W +: `CACHE_WORD_W] =
					presetWord({i[11:0], w[1:0], 2'b00});
		for (i = 0; i < nWords; i++)
			golden[i] = presetWord({i[13:0], 2'b00});
		for (i = 0; i < `CACHE_SETS; i++) begin
			refValid[0][i] = 1'b0;
			refValid[1][i] = 1'b0;
			refDirty[0][i] = 1'b0;
			refDirty[1][i] = 1'b0;
			refLru[i] = 1'b0;
		end

		addTest("read cold miss", cachePkg::opRead, 16'h1234, '0, 1'b0, presetWord(16'h1234));
		addTest("read repeat hit", cachePkg::opRead, 16'h1234, '0, 1'b1, presetWord(16'h1234));
		addTest("write hit", cachePkg::opWrite, 16'h1238, 32'hcafe0001, 1'b1, 32'hcafe0001);
		addTest("read written word", cachePkg::opRead, 16'h1238, '0, 1'b1, 32'hcafe0001);
		addTest("lru read A", cachePkg::opRead, 16'h2050, '0, 1'b0, presetWord(16'h2050));
		addTest("lru read B", cachePkg::opRead, 16'h2154, '0, 1'b0, presetWord(16'h2154));
		addTest("lru read A again", cachePkg::opRead, 16'h2058, '0, 1'b1, presetWord(16'h2058));
		addTest("lru read C", cachePkg::opRead, 16'h225c, '0, 1'b0, presetWord(16'h225c));
		addTest("lru A still hits", cachePkg::opRead, 16'h2050, '0, 1'b1, presetWord(16'h2050));
		addTest("lru B evicted", cachePkg::opRead, 16'h2150, '0, 1'b0, presetWord(16'h2150));
		addTest("wb fill other way", cachePkg::opRead, 16'h4230, '0, 1'b0,
			presetWord(16'h4230));
		addTest("wb dirty evict", cachePkg::opRead, 16'h5330, '0, 1'b0, presetWord(16'h5330));
		addTest("wb refill", cachePkg::opRead, 16'h1238, '0, 1'b0, 32'hcafe0001);
		addTest("write allocate", cachePkg::opWrite, 16'h6074, 32'h0badf00d, 1'b0,
			32'h0badf00d);
		addTest("inval dirty", cachePkg::opInvalidate, 16'h6070, '0, 1'b0, '0);
		addTest("read after flush", cachePkg::opRead, 16'h6074, '0, 1'b0, 32'h0badf00d);
		addTest("inval clean", cachePkg::opInvalidate, 16'h6070, '0, 1'b1, '0);
		addTest("read after inval", cachePkg::opRead, 16'h6070, '0, 1'b0, presetWord(16'h6070));
		addTest("inval absent", cachePkg::opInvalidate, 16'h7780, '0, 1'b1, '0);
		addTest("read absent line", cachePkg::opRead, 16'h7780, '0, 1'b0, presetWord(16'h7780));

		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		for (i = 0; i < nTests; i++) begin
			@(posedge clk);
			#2;
			op = testOp[i];
			addr = testAddr[i];
			writeData = testData[i];
			rdBefore = rdCount;
			wrBefore = wrCount;
			predictWriteback(testOp[i], testAddr[i], expWb, expWbAddr);
			if (testOp[i] == cachePkg::opWrite)
				golden[testAddr[i][15:2]] = testData[i];
			do @(negedge clk); while (!done);

			checkHit(testName[i], testHit[i], hit);
			if (testOp[i] != cachePkg::opInvalidate)
				checkWord(testName[i], testExp[i], readData);
			if (expWb) begin
				if (wrCount != wrBefore + 1) begin
					$display("%s: expected one writeback, saw %0d", testName[i],
						wrCount - wrBefore);
					stopRun();
				end
				checkAddr(testName[i], expWbAddr, lastWrAddr);
				for (w = 0; w < `CACHE_WORDS; w++)
					checkWord(testName[i], golden[{expWbAddr[15:4], w[1:0]}],
						memLines[expWbAddr[15:4]][w*`CACHE_WORD_W +: `CACHE_WORD_W]);
			end else if (wrCount != wrBefore) begin
				$display("%s: writeback issued where none was due", testName[i]);
				stopRun();
			end
			if (testHit[i] && rdCount != rdBefore) begin
				$display("%s: refill issued on a hit", testName[i]);
				stopRun();
			end
			// a miss on read or write refills the requested line
			if (!testHit[i] && testOp[i] != cachePkg::opInvalidate) begin
				if (rdCount != rdBefore + 1) begin
					$display("%s: expected one refill, saw %0d", testName[i],
						rdCount - rdBefore);
					stopRun();
				end
				checkAddr(testName[i], {testAddr[i][15:4], 4'h0}, lastRdAddr);
			end
		end

		@(posedge clk);
		#2;
		op = cachePkg::opNone;
		repeat (4) @(posedge clk);
		if (DUT.ctrl.props.failCount == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("%0d controller assertion failures", DUT.ctrl.props.failCount);
			stopRun();
		end
	end

endmodule

`default_nettype wire

//--- sim/cache_props.sv
`timescale 1ns/1ps
`default_nettype none

module cacheProps (
	input wire clk,
	input wire reset,
	input wire memRdReq,
	input wire memWrReq,
	input wire done,
	input wire cachePkg::ctrlStateT state
);

	int failCount = 0; // failed assertion count

	// one memory transaction at a time
	noDualReq: assert property (@(posedge clk) disable iff (reset)
		!(memRdReq && memWrReq))
		else begin
			failCount++;
			$error("refill and writeback requested in the same cycle");
		end

	noReqInReset: assert property (@(posedge clk)
		reset |=> !memRdReq && !memWrReq)
		else begin
			failCount++;
			$error("memory request while in reset");
		end

	noDoneInWait: assert property (@(posedge clk) disable iff (reset)
		(state == cachePkg::sFillWait || state == cachePkg::sFlushWait) |-> !done)
		else begin
			failCount++;
			$error("done raised while waiting on memory");
		end

endmodule

bind cacheCtrl cacheProps props (
	.clk(clk), .reset(reset), .memRdReq(memRdReq), .memWrReq(memWrReq),
	.done(done), .state(state)
);

`default_nettype wire

//--- sim/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk
);

	initial clk = 1'b0;

	always #20 clk = ~clk; // 40 ns period

endmodule

`default_nettype wire

//--- verilog/cacheTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheTop (
	input wire clk,
	input wire reset,
	input wire cachePkg::cacheOpT op,
	input wire cachePkg::addrT addr,
	input wire cachePkg::wordT writeData,
	input wire memRdReady,
	input wire cachePkg::lineT memRdLine,
	input wire memWrDone,
	output cachePkg::wordT readData,
	output logic done,
	output logic hit,
	output logic memRdReq,
	output cachePkg::addrT memRdAddr,
	output logic memWrReq,
	output cachePkg::addrT memWrAddr,
	output cachePkg::lineT memWrLine
);

	cachePkg::tagT tag;
	cachePkg::indexT index;
	cachePkg::wordSelT wordSel;

	logic isHit, victimDirty;
	logic fillEn, writeEn, touchEn, cleanEn, invalEn;
	cachePkg::wayT hitWay, victimWay, way;
	cachePkg::tagT victimTag;

	// tag | index | word | byte
	assign tag = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign index = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign wordSel = addr[`CACHE_OFFSET_W-1 -: $bits(cachePkg::wordSelT)];

	cacheStore store (
		.clk(clk), .reset(reset), .index(index), .tag(tag), .wordSel(wordSel),
		.writeData(writeData), .fillLine(memRdLine), .fillEn(fillEn),
		.writeEn(writeEn), .touchEn(touchEn), .cleanEn(cleanEn), .invalEn(invalEn),
		.way(way), .isHit(isHit), .hitWay(hitWay), .victimWay(victimWay),
		.victimDirty(victimDirty), .victimTag(victimTag), .victimLine(memWrLine),
		.readData(readData)
	);

	cacheCtrl ctrl (
		.clk(clk), .reset(reset), .op(op), .index(index), .tag(tag), .isHit(isHit),
		.hitWay(hitWay), .victimWay(victimWay), .victimDirty(victimDirty),
		.victimTag(victimTag), .memRdReady(memRdReady), .memWrDone(memWrDone),
		.fillEn(fillEn), .writeEn(writeEn), .touchEn(touchEn), .cleanEn(cleanEn),
		.invalEn(invalEn), .way(way), .memRdReq(memRdReq), .memRdAddr(memRdAddr),
		.memWrReq(memWrReq), .memWrAddr(memWrAddr), .done(done), .hit(hit)
	);

endmodule

`default_nettype wire
